// ==== bert_rx_pkg.sv ====
`include "bert_rx_settings.svh"

package bert_rx_pkg;

	//////////////////////////////
	// Vector types

	// Raw word from the transceiver
	typedef logic [`BERT_RX_WORD_W-1:0] rx_word_t;

	// Gearbox output, half a block
	typedef logic [`BERT_HALF_W-1:0] half_block_t;

	// Full block, sync header in the top two bits
	typedef logic [`BERT_BLOCK_W-1:0] block_t;

	typedef logic [`BERT_HDR_W-1:0] sync_hdr_t;
	typedef logic [`BERT_PAYLOAD_W-1:0] payload_t;

	//////////////////////////////
	// Block sync FSM

	typedef enum logic [1:0] {
		SYNC_HUNT,
		SYNC_SLIP_WAIT,
		SYNC_LOCKED
	} sync_state_t;

endpackage

// ==== bert_rx_settings.svh ====
`ifndef BERT_RX_SETTINGS_SVH
`define BERT_RX_SETTINGS_SVH

//////////////////////////////
// Datapath widths

// Transceiver word from the GTX
`define BERT_RX_WORD_W 32
// Half of a 66-bit block
`define BERT_HALF_W 33
`define BERT_BLOCK_W 66
`define BERT_PAYLOAD_W 64
`define BERT_HDR_W 2

//////////////////////////////
// Block sync thresholds

// Consecutive good headers to declare lock
`define BERT_LOCK_GOOD 64
// Headers per error window while locked
`define BERT_BAD_WINDOW 64
// Bad headers per window that drop lock
`define BERT_BAD_LIMIT 16
// Headers ignored after each slip
`define BERT_SLIP_HOLDOFF 4

//////////////////////////////
// Scrambler polynomial x^58 + x^39 + 1

`define BERT_SCR_TAP_A 39
`define BERT_SCR_TAP_B 58

`endif

// ==== block_sync_66b.sv ====
`timescale 1ns/1ps
`include "bert_rx_settings.svh"

module block_sync_66b import bert_rx_pkg::*; (
	input logic lane0_rxclk,
	input logic reset,
	input block_t block,
	input logic block_strobe,
	output logic bitslip,
	output logic block_lock
);

	localparam int GOOD_W = $clog2(`BERT_LOCK_GOOD);
	localparam int WIN_W = $clog2(`BERT_BAD_WINDOW);
	localparam int BAD_W = $clog2(`BERT_BAD_LIMIT);
	localparam int HOLD_W = $clog2(`BERT_SLIP_HOLDOFF);

	sync_state_t state;
	logic [GOOD_W-1:0] good_cnt;
	logic [WIN_W-1:0] win_cnt;
	logic [BAD_W-1:0] bad_cnt;
	logic [HOLD_W-1:0] hold_cnt;

	//////////////////////////////
	// Header check

	sync_hdr_t header;
	logic hdr_good;

	always_comb begin
		header = block[`BERT_BLOCK_W-1 -: `BERT_HDR_W];
		// Only 01 and 10 are legal
		hdr_good = header[1] ^ header[0];
	end

	//////////////////////////////
	// Lock FSM

	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			state <= SYNC_HUNT;
			good_cnt <= '0;
			win_cnt <= '0;
			bad_cnt <= '0;
			hold_cnt <= '0;
			bitslip <= 1'b0;
			block_lock <= 1'b0;
		end else begin
			// Slip is a single-cycle pulse
			bitslip <= 1'b0;

			if (block_strobe) begin
				case (state)
					SYNC_HUNT: begin
						if (!hdr_good) begin
							bitslip <= 1'b1;
							good_cnt <= '0;
							hold_cnt <= '0;
							state <= SYNC_SLIP_WAIT;
						end else if (good_cnt == GOOD_W'(`BERT_LOCK_GOOD - 1)) begin
							// Last good header of the run
							good_cnt <= '0;
							win_cnt <= '0;
							bad_cnt <= '0;
							block_lock <= 1'b1;
							state <= SYNC_LOCKED;
						end else begin
							good_cnt <= good_cnt + GOOD_W'(1);
						end
					end

					// Let the gearbox and demux refill after a slip
					SYNC_SLIP_WAIT: begin
						if (hold_cnt == HOLD_W'(`BERT_SLIP_HOLDOFF - 1)) begin
							hold_cnt <= '0;
							state <= SYNC_HUNT;
						end else begin
							hold_cnt <= hold_cnt + HOLD_W'(1);
						end
					end

					SYNC_LOCKED: begin
						if (!hdr_good && (bad_cnt == BAD_W'(`BERT_BAD_LIMIT - 1))) begin
							// Too many errors in this window, start over
							bitslip <= 1'b1;
							block_lock <= 1'b0;
							good_cnt <= '0;
							hold_cnt <= '0;
							state <= SYNC_SLIP_WAIT;
						end else if (win_cnt == WIN_W'(`BERT_BAD_WINDOW - 1)) begin
							// End of window
							win_cnt <= '0;
							bad_cnt <= '0;
						end else begin
							win_cnt <= win_cnt + WIN_W'(1);
							bad_cnt <= bad_cnt + BAD_W'(!hdr_good);
						end
					end

					default: begin
						state <= SYNC_HUNT;
					end
				endcase
			end
		end
	end

	a_slip_pulse: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		bitslip |=> !bitslip
	);

	a_lock_state: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		block_lock |-> (state == SYNC_LOCKED)
	);

endmodule

// ==== descrambler_64b66b.sv ====
`timescale 1ns/1ps
`include "bert_rx_settings.svh"

module descrambler_64b66b import bert_rx_pkg::*; (
	input logic lane0_rxclk,
	input logic reset,
	input block_t block,
	input logic block_strobe,
	output logic block_valid,
	output sync_hdr_t block_header,
	output payload_t block_data
);

	localparam int HIST_W = `BERT_SCR_TAP_B;

	// Last 58 received line bits, newest at bit 0
	logic [HIST_W-1:0] hist;

	logic [HIST_W-1:0] hist_next;
	payload_t scrambled;
	payload_t clear;

	//////////////////////////////
	// Unrolled descrambler

	always_comb begin
		scrambled = block[`BERT_PAYLOAD_W-1:0];
		hist_next = hist;
		// LSB first, one bit per step
		for (int i = 0; i < `BERT_PAYLOAD_W; i++) begin
			clear[i] = scrambled[i] ^ hist_next[`BERT_SCR_TAP_A-1] ^ hist_next[`BERT_SCR_TAP_B-1];
			// Self-synchronous, history takes the line bit
			hist_next = {hist_next[HIST_W-2:0], scrambled[i]};
		end
	end

	//////////////////////////////
	// Output registers

	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			block_valid <= 1'b0;
		end else begin
			block_valid <= block_strobe;
		end
	end

	always_ff @(posedge lane0_rxclk) begin
		if (block_strobe) begin
			hist <= hist_next;
			// Header is not scrambled
			block_header <= block[`BERT_BLOCK_W-1 -: `BERT_HDR_W];
			block_data <= clear;
		end
	end

endmodule

// ==== half_block_demux.sv ====
`timescale 1ns/1ps
`include "bert_rx_settings.svh"

module half_block_demux import bert_rx_pkg::*; (
	input logic lane0_rxclk,
	input logic reset,
	input half_block_t half_data,
	input logic half_valid,
	output block_t block,
	output logic block_strobe
);

	// 0 = expecting first half, 1 = expecting second half
	logic phase;

	//////////////////////////////
	// Phase and strobe

	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			phase <= 1'b0;
			block_strobe <= 1'b0;
		end else begin
			block_strobe <= half_valid && phase;
			if (half_valid) begin
				phase <= !phase;
			end
		end
	end

	//////////////////////////////
	// Block assembly

	always_ff @(posedge lane0_rxclk) begin
		if (half_valid) begin
			if (phase) begin
				// Second half, low bits
				block[`BERT_HALF_W-1:0] <= half_data;
			end else begin
				// First half carries the sync header
				block[`BERT_BLOCK_W-1 -: `BERT_HALF_W] <= half_data;
			end
		end
	end

	// Blocks are at least two gearbox outputs apart
	a_strobe_single: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		block_strobe |=> !block_strobe
	);

endmodule

// ==== lane_rx_64b66b.sv ====
`timescale 1ns/1ps

module lane_rx_64b66b import bert_rx_pkg::*; (
	input logic lane0_rxclk,
	input logic reset,
	input rx_word_t rx_data,
	output logic block_valid,
	output sync_hdr_t block_header,
	output payload_t block_data,
	output logic block_lock
);

	//////////////////////////////
	// 32 to 33 gearbox

	half_block_t half_data;
	logic half_valid;
	logic bitslip;

	rx_gearbox_32_33 u_gearbox (
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.rx_data(rx_data),
		.bitslip(bitslip),
		.half_data(half_data),
		.half_valid(half_valid)
	);

	//////////////////////////////
	// 33 to 66 demux

	block_t block;
	logic block_strobe;

	half_block_demux u_demux (
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.half_data(half_data),
		.half_valid(half_valid),
		.block(block),
		.block_strobe(block_strobe)
	);

	//////////////////////////////
	// Block alignment and payload recovery

	// Drives bitslip back into the gearbox
	block_sync_66b u_block_sync (
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.block(block),
		.block_strobe(block_strobe),
		.bitslip(bitslip),
		.block_lock(block_lock)
	);

	descrambler_64b66b u_descrambler (
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.block(block),
		.block_strobe(block_strobe),
		.block_valid(block_valid),
		.block_header(block_header),
		.block_data(block_data)
	);

endmodule

// ==== rx_gearbox_32_33.sv ====
`timescale 1ns/1ps
`include "bert_rx_settings.svh"

module rx_gearbox_32_33 import bert_rx_pkg::*; (
	input logic lane0_rxclk,
	input logic reset,
	input rx_word_t rx_data,
	input logic bitslip,
	output half_block_t half_data,
	output logic half_valid
);

	// Two words of storage cover the worst case fill
	localparam int BUF_W = 2 * `BERT_RX_WORD_W;
	localparam int FILL_W = $clog2(BUF_W + 1);
	localparam int HALF_W = `BERT_HALF_W;

	//////////////////////////////
	// Bit buffer with the oldest bit at the MSB

	logic [BUF_W-1:0] bit_buf;
	logic [FILL_W-1:0] fill;

	logic emit;
	logic [BUF_W-1:0] rem_buf;
	logic [FILL_W-1:0] rem_fill;
	logic [BUF_W-1:0] next_buf;
	logic [FILL_W-1:0] next_fill;

	always_comb begin
		// Enough bits buffered for a half-block
		emit = (fill >= FILL_W'(HALF_W));

		// Pop the outgoing half-block off the front
		if (emit) begin
			rem_buf = bit_buf << HALF_W;
			rem_fill = fill - FILL_W'(HALF_W);
		end else begin
			rem_buf = bit_buf;
			rem_fill = fill;
		end

		// Clear stale bits below the valid region
		rem_buf = rem_buf & ~({BUF_W{1'b1}} >> rem_fill);

		// New word lands right behind the leftover bits
		next_buf = rem_buf | ({rx_data, {`BERT_RX_WORD_W{1'b0}}} >> rem_fill);
		next_fill = rem_fill + FILL_W'(`BERT_RX_WORD_W);

		// Bitslip throws away the oldest remaining bit
		if (bitslip) begin
			next_buf = next_buf << 1;
			next_fill = next_fill - FILL_W'(1);
		end
	end

	//////////////////////////////
	// Registers

	// Control state
	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			fill <= '0;
			half_valid <= 1'b0;
		end else begin
			fill <= next_fill;
			half_valid <= emit;
		end
	end

	// Bit buffer and outgoing half-block
	always_ff @(posedge lane0_rxclk) begin
		bit_buf <= next_buf;
		if (emit) begin
			half_data <= bit_buf[BUF_W-1 -: HALF_W];
		end
	end

	// Fill must stay inside the buffer for any slip pattern
	a_fill_in_range: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		fill <= FILL_W'(BUF_W)
	);

endmodule

// ==== sources.f ====
+incdir+.
bert_rx_pkg.sv
rx_gearbox_32_33.sv
half_block_demux.sv
block_sync_66b.sv
descrambler_64b66b.sv
lane_rx_64b66b.sv
tb_lane_rx_64b66b.sv

// ==== tb_lane_rx_64b66b.sv ====
`timescale 1ns/1ps
`include "bert_rx_settings.svh"

module tb_lane_rx_64b66b import bert_rx_pkg::*; ();

	localparam int SEED = 24009;
	// Checked blocks per clean run, three runs in all
	localparam int CHECK_RUN = 200;
	localparam int NUM_BLOCKS = 3 * CHECK_RUN;
	localparam int ACQ_CYCLES = 20000;
	localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 70 + ACQ_CYCLES;
	// Under half a block per cycle, so the pool outlasts the watchdog
	localparam int POOL = WATCHDOG_CYCLES / 2 + 128;

	typedef enum int {CMP_WAIT, CMP_SKIP, CMP_FIND, CMP_CHECK} cmp_mode_t;

	logic lane0_rxclk;
	logic reset;
	rx_word_t rx_data;
	logic block_valid;
	sync_hdr_t block_header;
	payload_t block_data;
	logic block_lock;

	lane_rx_64b66b u_dut (
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.rx_data(rx_data),
		.block_valid(block_valid),
		.block_header(block_header),
		.block_data(block_data),
		.block_lock(block_lock)
	);

	initial begin
		lane0_rxclk = 1'b0;
		forever #10 lane0_rxclk = ~lane0_rxclk;
	end

	//////////////////////////////
	// Line model

	// Clear payloads and good headers, drawn up front
	payload_t clear_mem [POOL];
	sync_hdr_t hdr_mem [POOL];
	// Header sent as 00
	bit bad_mem [POOL];
	int blocks_sent = 0;
	bit bit_q [$];
	// Newest scrambled bit at bit 0
	logic [`BERT_SCR_TAP_B-1:0] scr_hist = '0;
	bit stream_en = 1'b0;
	int corrupt_req = 0;
	int corrupt_done = 0;
	rx_word_t line_word;

	// x^58 + x^39 + 1, payload LSB first
	task automatic scramble(input payload_t clear, output payload_t line);
		for (int i = 0; i < `BERT_PAYLOAD_W; i++) begin
			line[i] = clear[i] ^ scr_hist[`BERT_SCR_TAP_A-1] ^ scr_hist[`BERT_SCR_TAP_B-1];
			scr_hist = {scr_hist[`BERT_SCR_TAP_B-2:0], line[i]};
		end
	endtask

	task automatic append_block();
		payload_t line;
		block_t blk;
		bit corrupt;
		corrupt = (corrupt_done < corrupt_req);
		if (corrupt) begin
			corrupt_done++;
		end
		bad_mem[blocks_sent] = corrupt;
		scramble(clear_mem[blocks_sent], line);
		blk = {(corrupt ? 2'b00 : hdr_mem[blocks_sent]), line};
		// MSB first on the line
		for (int i = `BERT_BLOCK_W - 1; i >= 0; i--) begin
			bit_q.push_back(blk[i]);
		end
		blocks_sent++;
	endtask

	task automatic next_word(output rx_word_t word);
		while (bit_q.size() < `BERT_RX_WORD_W) begin
			append_block();
		end
		// Oldest bit lands in the MSB
		for (int i = `BERT_RX_WORD_W - 1; i >= 0; i--) begin
			word[i] = bit_q.pop_front();
		end
	endtask

	// Idle line is all zeros
	always @(posedge lane0_rxclk) begin
		if (stream_en) begin
			next_word(line_word);
			rx_data <= line_word;
		end else begin
			rx_data <= '0;
		end
	end

	//////////////////////////////
	// Reference and comparison

	function automatic block_t expected_block(int n);
		sync_hdr_t hdr;
		hdr = bad_mem[n] ? 2'b00 : hdr_mem[n];
		return {hdr, clear_mem[n]};
	endfunction

	// Newest first, payloads are unique in practice
	function automatic int find_block(payload_t data);
		for (int i = blocks_sent - 1; i >= 0; i--) begin
			if (clear_mem[i] == data) begin
				return i;
			end
		end
		return -1;
	endfunction

	cmp_mode_t mode = CMP_WAIT;
	int exp_idx = 0;
	int checks_done = 0;
	int match_count = 0;
	int data_errors = 0;
	int lock_errors = 0;
	int timeout_errors = 0;
	bit drop_allowed = 1'b0;
	string phase = "reset";

	initial begin : compare_blocks
		block_t exp_blk;
		int hit;
		forever begin
			@(negedge lane0_rxclk);
			if (reset || block_lock !== 1'b1) begin
				mode = CMP_WAIT;
			end else begin
				// History may be unsettled on the first block after lock
				if (mode == CMP_WAIT) begin
					mode = CMP_SKIP;
				end
				if (block_valid) begin
					case (mode)
						CMP_SKIP: begin
							mode = CMP_FIND;
						end
						CMP_FIND: begin
							hit = find_block(block_data);
							assert (hit >= 0) else begin
								data_errors++;
								$display("[ERROR] %0t: payload %h matches no sent block",
									$time, block_data);
							end
							if (hit >= 0) begin
								exp_idx = hit + 1;
								match_count++;
								mode = CMP_CHECK;
							end
						end
						default: begin
							exp_blk = expected_block(exp_idx);
							assert ({block_header, block_data} === exp_blk) else begin
								data_errors++;
								$display("[ERROR] %0t: block %0d got %b_%h expected %b_%h",
									$time, exp_idx, block_header, block_data,
									exp_blk[65:64], exp_blk[63:0]);
							end
							exp_idx++;
							checks_done++;
						end
					endcase
				end
			end
		end
	end

	// Lock may only fall during the long burst
	initial begin : watch_lock
		logic prev_lock;
		prev_lock = 1'b0;
		forever begin
			@(negedge lane0_rxclk);
			assert (drop_allowed || !(prev_lock && !block_lock)) else begin
				lock_errors++;
				$display("[ERROR] %0t: block_lock fell unexpectedly", $time);
			end
			prev_lock = block_lock;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge lane0_rxclk);
		$display("Watchdog expired after %0d cycles, the run hung in phase: %s",
			WATCHDOG_CYCLES, phase);
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////
	// Sequence

	task automatic wait_lock_level(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		while (block_lock !== level && n < limit) begin
			@(negedge lane0_rxclk);
			n++;
		end
		ok = (block_lock === level);
	endtask

	task automatic wait_checks(input int count, output bit ok);
		int target;
		int n;
		target = checks_done + count;
		n = 0;
		while (checks_done < target && n < count * 70) begin
			@(negedge lane0_rxclk);
			n++;
		end
		ok = (checks_done >= target);
	endtask

	task automatic check_progress(input bit ok, input string what);
		assert (ok) else begin
			timeout_errors++;
			$display("Timeout at %0t: %s", $time, what);
		end
	endtask

	initial begin : run_test
		bit ok;
		int offset;
		void'($urandom(SEED));
		reset = 1'b1;
		rx_data = '0;
		for (int i = 0; i < POOL; i++) begin
			clear_mem[i] = {$urandom, $urandom};
			hdr_mem[i] = ($urandom % 2) ? 2'b01 : 2'b10;
			bad_mem[i] = 1'b0;
		end
		offset = $urandom % `BERT_BLOCK_W;

		// Three cycles of reset, then an idle line
		repeat (3) @(posedge lane0_rxclk);
		reset <= 1'b0;
		phase = "idle line";
		for (int i = 0; i < 100; i++) begin
			@(negedge lane0_rxclk);
			// Pipeline is still empty for the first few cycles
			assert (!block_lock && (i >= 4 || !block_valid)) else begin
				lock_errors++;
				$display("[ERROR] %0t: output active before any valid header run", $time);
			end
		end

		// Stream starts at a random bit offset
		for (int i = 0; i < offset; i++) begin
			bit_q.push_back(1'($urandom));
		end
		stream_en = 1'b1;
		phase = "first acquisition";
		wait_lock_level(1'b1, ACQ_CYCLES, ok);
		check_progress(ok, "block_lock never rose on the first acquisition");
		if (ok) begin
			phase = "clean blocks after first lock";
			wait_checks(CHECK_RUN, ok);
			check_progress(ok, "block checks stalled after the first lock");
		end
		if (ok) begin
			// Eight bad headers stay under the window limit
			phase = "8 bad headers while locked";
			corrupt_req = corrupt_req + 8;
			wait_checks(CHECK_RUN, ok);
			check_progress(ok, "block checks stalled after 8 bad headers");
			assert (match_count == 1) else begin
				data_errors++;
				$display("[ERROR] %0t: data checks lost the block sequence", $time);
			end
		end
		if (ok) begin
			// 34 in a row puts at least 16 inside one window
			phase = "loss of lock";
			drop_allowed = 1'b1;
			corrupt_req = corrupt_req + 34;
			wait_lock_level(1'b0, 200, ok);
			check_progress(ok, "block_lock did not fall after the bad header burst");
		end
		if (ok) begin
			phase = "second acquisition";
			wait_lock_level(1'b1, ACQ_CYCLES, ok);
			check_progress(ok, "block_lock never rose on the second acquisition");
		end
		if (ok) begin
			drop_allowed = 1'b0;
			phase = "clean blocks after relock";
			wait_checks(CHECK_RUN, ok);
			check_progress(ok, "block checks stalled after the relock");
			assert (match_count == 2) else begin
				data_errors++;
				$display("[ERROR] %0t: data checks did not resync after relock", $time);
			end
		end

		$display("Summary: %0d blocks checked, %0d data errors, %0d lock errors, %0d timeouts",
			checks_done, data_errors, lock_errors, timeout_errors);
		if (data_errors + lock_errors + timeout_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
